/* rtl/maze_pkg.sv */
package maze_pkg;

	// Grid geometry
	localparam int grid_w  = 32;
	localparam int grid_h  = 24;
	localparam int tile_px = 5;

	typedef logic [4:0] tile_x_t;
	typedef logic [4:0] tile_y_t;
	typedef logic [7:0] pix_x_t;
	typedef logic [6:0] pix_y_t;
	typedef logic [5:0] colour_t;
	typedef logic [3:0] dir_t;
	typedef logic       level_t;

	// Tile codes double as display colours
	localparam colour_t c_blank  = 6'h00;
	localparam colour_t c_trap   = 6'h30;
	localparam colour_t c_goal   = 6'h0C;
	localparam colour_t c_wall   = 6'h3F;
	localparam colour_t c_key    = 6'h3C;
	localparam colour_t c_player = 6'h03;

	localparam dir_t dir_up    = 4'd8;
	localparam dir_t dir_down  = 4'd4;
	localparam dir_t dir_left  = 4'd2;
	localparam dir_t dir_right = 4'd1;

	typedef enum logic [1:0] {
		s_load,
		s_draw,
		s_play,
		s_swap
	} game_state_t;

	typedef enum logic [2:0] {
		mo_none,
		mo_free,
		mo_blocked,
		mo_trap,
		mo_goal,
		mo_key
	} move_outcome_t;

	// Key and goal positions per level
	localparam tile_x_t key0_x  = 5'd12;
	localparam tile_y_t key0_y  = 5'd17;
	localparam tile_x_t goal0_x = 5'd11;
	localparam tile_y_t goal0_y = 5'd2;
	localparam tile_x_t key1_x  = 5'd5;
	localparam tile_y_t key1_y  = 5'd5;
	localparam tile_x_t goal1_x = 5'd20;
	localparam tile_y_t goal1_y = 5'd10;

endpackage

/* rtl/tile_write_if.sv */
`timescale 1ns/100ps

interface tile_write_if import maze_pkg::*; ();

	logic    we;
	tile_x_t x;
	tile_y_t y;
	colour_t tile;

	modport writer (
		output we,
		output x,
		output y,
		output tile
	);

	modport mem (
		input we,
		input x,
		input y,
		input tile
	);

endinterface

/* rtl/level_rom.sv */
`timescale 1ns/100ps

module level_rom import maze_pkg::*; (
	input  level_t  level,
	input  tile_x_t x,
	input  tile_y_t y,
	output colour_t tile
);

	logic border;

	assign border = (x == '0) || (x == tile_x_t'(grid_w - 1)) ||
	                (y == '0) || (y == tile_y_t'(grid_h - 1));

	always_comb
	begin
		tile = c_blank;
		if (border)
		begin
			tile = c_wall;
		end
		else if (level == 1'b0)
		begin
			// Long divider wall, trap strip above the goal
			if (x == 5'd19)
				tile = c_wall;
			else if (y == 5'd1 && x >= 5'd9 && x <= 5'd11)
				tile = c_trap;
			else if (x == key0_x && y == key0_y)
				tile = c_key;
		end
		else
		begin
			if (y == 5'd15 && x >= 5'd17 && x <= 5'd23)
				tile = c_trap;
			else if (x == key1_x && y == key1_y)
				tile = c_key;
		end
	end

endmodule

/* rtl/map_writer.sv */
`timescale 1ns/100ps

module map_writer import maze_pkg::*; (
	input  logic         clock,
	input  logic         rst_n,
	input  logic         load_start,
	input  logic         swap_start,
	input  level_t       level,
	input  colour_t      rom_tile,
	output tile_x_t      rom_x,
	output tile_y_t      rom_y,
	output logic         write_done,
	tile_write_if.writer wr
);

	logic    loading;
	logic    swap_key;
	logic    swap_goal;
	logic    last_tile;
	tile_x_t cnt_x;
	tile_y_t cnt_y;

	assign last_tile = (cnt_x == tile_x_t'(grid_w - 1)) && (cnt_y == tile_y_t'(grid_h - 1));

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			loading   <= 1'b0;
			swap_key  <= 1'b0;
			swap_goal <= 1'b0;
			cnt_x     <= '0;
			cnt_y     <= '0;
		end
		else
		begin
			// Swap is two fixed writes, key first
			swap_key  <= swap_start;
			swap_goal <= swap_key;
			if (load_start)
			begin
				loading <= 1'b1;
				cnt_x   <= '0;
				cnt_y   <= '0;
			end
			else if (loading)
			begin
				if (last_tile)
				begin
					loading <= 1'b0;
				end
				else if (cnt_x == tile_x_t'(grid_w - 1))
				begin
					cnt_x <= '0;
					cnt_y <= cnt_y + 1'b1;
				end
				else
				begin
					cnt_x <= cnt_x + 1'b1;
				end
			end
		end
	end

	assign rom_x = cnt_x;
	assign rom_y = cnt_y;

	always_comb
	begin
		wr.we   = loading | swap_key | swap_goal;
		wr.x    = cnt_x;
		wr.y    = cnt_y;
		wr.tile = rom_tile;
		if (swap_key)
		begin
			wr.x    = level ? key1_x : key0_x;
			wr.y    = level ? key1_y : key0_y;
			wr.tile = c_blank;
		end
		else if (swap_goal)
		begin
			wr.x    = level ? goal1_x : goal0_x;
			wr.y    = level ? goal1_y : goal0_y;
			wr.tile = c_goal;
		end
	end

	assign write_done = (loading && last_tile) || swap_goal;

endmodule

/* rtl/tile_map.sv */
`timescale 1ns/100ps

module tile_map import maze_pkg::*; (
	input  logic      clock,
	input  tile_x_t   draw_x,
	input  tile_y_t   draw_y,
	input  tile_x_t   probe_x,
	input  tile_y_t   probe_y,
	output colour_t   draw_tile,
	output colour_t   probe_tile,
	tile_write_if.mem wr
);

	colour_t    mem [0:grid_w*grid_h-1];
	logic [9:0] wr_addr;
	logic [9:0] draw_addr;
	logic [9:0] probe_addr;

	// Row-major, a row is exactly 32 tiles wide
	assign wr_addr    = {wr.y, wr.x};
	assign draw_addr  = {draw_y, draw_x};
	assign probe_addr = {probe_y, probe_x};

	always_ff @(posedge clock)
	begin
		if (wr.we)
			mem[wr_addr] <= wr.tile;
	end

	assign draw_tile  = mem[draw_addr];
	assign probe_tile = mem[probe_addr];

endmodule

/* rtl/frame_drawer.sv */
`timescale 1ns/100ps

module frame_drawer import maze_pkg::*; (
	input  logic    clock,
	input  logic    rst_n,
	input  logic    draw_start,
	input  logic    pixel_tick,
	input  colour_t draw_tile,
	output tile_x_t draw_x,
	output tile_y_t draw_y,
	output pix_x_t  pix_x,
	output pix_y_t  pix_y,
	output colour_t pix_colour,
	output logic    plot,
	output logic    draw_done
);

	logic active;
	logic last_tile;

	assign last_tile = (draw_x == tile_x_t'(grid_w - 1)) && (draw_y == tile_y_t'(grid_h - 1));

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			active <= 1'b0;
			draw_x <= '0;
			draw_y <= '0;
		end
		else if (draw_start)
		begin
			active <= 1'b1;
			draw_x <= '0;
			draw_y <= '0;
		end
		else if (active && pixel_tick)
		begin
			if (last_tile)
			begin
				active <= 1'b0;
			end
			else if (draw_x == tile_x_t'(grid_w - 1))
			begin
				draw_x <= '0;
				draw_y <= draw_y + 1'b1;
			end
			else
			begin
				draw_x <= draw_x + 1'b1;
			end
		end
	end

	// One tile per tick, the plotter fills the 5x5 block
	assign plot       = active & pixel_tick;
	assign draw_done  = plot & last_tile;
	assign pix_x      = pix_x_t'(draw_x) * pix_x_t'(tile_px);
	assign pix_y      = pix_y_t'(draw_y) * pix_y_t'(tile_px);
	assign pix_colour = draw_tile;

endmodule

/* rtl/move_checker.sv */
`timescale 1ns/100ps

module move_checker import maze_pkg::*; (
	input  logic          clock,
	input  logic          rst_n,
	input  pix_x_t        player_x,
	input  pix_y_t        player_y,
	input  dir_t          direction,
	input  colour_t       probe_tile,
	output tile_x_t       probe_x,
	output tile_y_t       probe_y,
	output move_outcome_t outcome
);

	// One extra bit so the +5 edge does not wrap
	logic [8:0] near_x;
	logic [7:0] near_y;

	always_comb
	begin
		near_x = {1'b0, player_x};
		near_y = {1'b0, player_y};
		case (direction)
			dir_up:    near_y = {1'b0, player_y} - 8'd1;
			dir_down:  near_y = {1'b0, player_y} + 8'(tile_px);
			dir_left:  near_x = {1'b0, player_x} - 9'd1;
			dir_right: near_x = {1'b0, player_x} + 9'(tile_px);
			default:   near_x = {1'b0, player_x};
		endcase
	end

	assign probe_x = tile_x_t'(near_x / 9'(tile_px));
	assign probe_y = tile_y_t'(near_y / 8'(tile_px));

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			outcome <= mo_none;
		end
		else if (!$onehot(direction))
		begin
			outcome <= mo_none;
		end
		else
		begin
			case (probe_tile)
				c_wall:  outcome <= mo_blocked;
				c_trap:  outcome <= mo_trap;
				c_goal:  outcome <= mo_goal;
				c_key:   outcome <= mo_key;
				default: outcome <= mo_free;
			endcase
		end
	end

endmodule

/* rtl/game_fsm.sv */
`timescale 1ns/100ps

module game_fsm import maze_pkg::*; (
	input  logic          clock,
	input  logic          rst_n,
	input  move_outcome_t outcome,
	input  logic          write_done,
	input  logic          draw_done,
	output logic          load_start,
	output logic          swap_start,
	output logic          draw_start,
	output level_t        level,
	output logic          play,
	output logic          stop,
	output logic          restart
);

	game_state_t state;

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			// Coming out of reset, level 0 is loaded straight away
			state      <= s_load;
			load_start <= 1'b1;
			swap_start <= 1'b0;
			draw_start <= 1'b0;
			level      <= 1'b0;
			stop       <= 1'b0;
			restart    <= 1'b1;
		end
		else
		begin
			load_start <= 1'b0;
			swap_start <= 1'b0;
			draw_start <= 1'b0;
			case (state)
				s_load:
				begin
					stop <= 1'b0;
					if (write_done)
					begin
						state      <= s_draw;
						draw_start <= 1'b1;
					end
				end
				s_draw:
				begin
					if (draw_done)
					begin
						state   <= s_play;
						restart <= 1'b0;
					end
				end
				s_swap:
				begin
					if (write_done)
					begin
						state      <= s_draw;
						draw_start <= 1'b1;
					end
				end
				s_play:
				begin
					case (outcome)
						mo_none:    stop <= 1'b0;
						mo_blocked: stop <= 1'b1;
						mo_trap:
						begin
							stop       <= 1'b1;
							restart    <= 1'b1;
							state      <= s_load;
							load_start <= 1'b1;
						end
						mo_goal:
						begin
							stop       <= 1'b1;
							restart    <= 1'b1;
							level      <= ~level;
							state      <= s_load;
							load_start <= 1'b1;
						end
						mo_key:
						begin
							state      <= s_swap;
							swap_start <= 1'b1;
						end
						default: stop <= stop;
					endcase
				end
				default: state <= s_load;
			endcase
		end
	end

	assign play = (state == s_play);

endmodule

/* rtl/maze_top.sv */
`timescale 1ns/100ps

module maze_top import maze_pkg::*; (
	input  logic    clock,
	input  logic    rst_n,
	input  logic    pixel_tick,
	input  pix_x_t  player_x,
	input  pix_y_t  player_y,
	input  dir_t    direction,
	output colour_t colour,
	output pix_x_t  x_out,
	output pix_y_t  y_out,
	output logic    plot,
	output logic    stop,
	output logic    restart
);

	logic          load_start;
	logic          swap_start;
	logic          draw_start;
	logic          write_done;
	logic          draw_done;
	logic          play;
	level_t        level;
	move_outcome_t outcome;
	tile_x_t       rom_x;
	tile_y_t       rom_y;
	tile_x_t       draw_x;
	tile_y_t       draw_y;
	tile_x_t       probe_x;
	tile_y_t       probe_y;
	colour_t       rom_tile;
	colour_t       draw_tile;
	colour_t       probe_tile;
	colour_t       pix_colour;
	pix_x_t        pix_x;
	pix_y_t        pix_y;

	tile_write_if wr_bus ();

	game_fsm u_fsm (
		.clock      (clock),
		.rst_n      (rst_n),
		.outcome    (outcome),
		.write_done (write_done),
		.draw_done  (draw_done),
		.load_start (load_start),
		.swap_start (swap_start),
		.draw_start (draw_start),
		.level      (level),
		.play       (play),
		.stop       (stop),
		.restart    (restart)
	);

	map_writer u_writer (
		.clock      (clock),
		.rst_n      (rst_n),
		.load_start (load_start),
		.swap_start (swap_start),
		.level      (level),
		.rom_tile   (rom_tile),
		.rom_x      (rom_x),
		.rom_y      (rom_y),
		.write_done (write_done),
		.wr         (wr_bus.writer)
	);

	level_rom u_rom (
		.level (level),
		.x     (rom_x),
		.y     (rom_y),
		.tile  (rom_tile)
	);

	tile_map u_map (
		.clock      (clock),
		.draw_x     (draw_x),
		.draw_y     (draw_y),
		.probe_x    (probe_x),
		.probe_y    (probe_y),
		.draw_tile  (draw_tile),
		.probe_tile (probe_tile),
		.wr         (wr_bus.mem)
	);

	frame_drawer u_drawer (
		.clock      (clock),
		.rst_n      (rst_n),
		.draw_start (draw_start),
		.pixel_tick (pixel_tick),
		.draw_tile  (draw_tile),
		.draw_x     (draw_x),
		.draw_y     (draw_y),
		.pix_x      (pix_x),
		.pix_y      (pix_y),
		.pix_colour (pix_colour),
		.plot       (plot),
		.draw_done  (draw_done)
	);

	move_checker u_checker (
		.clock      (clock),
		.rst_n      (rst_n),
		.player_x   (player_x),
		.player_y   (player_y),
		.direction  (direction),
		.probe_tile (probe_tile),
		.probe_x    (probe_x),
		.probe_y    (probe_y),
		.outcome    (outcome)
	);

	// Player sprite in play, map pixels otherwise
	assign colour = play ? c_player : pix_colour;
	assign x_out  = play ? player_x : pix_x;
	assign y_out  = play ? player_y : pix_y;

endmodule

/* testbench/maze_sva.sv */
`timescale 1ns/100ps

module maze_sva (
	input logic clock,
	input logic rst_n,
	input logic plot,
	input logic play,
	input logic stop,
	input logic restart,
	input logic load_start,
	input logic write_done
);

	int unsigned failures;
	logic        in_load;

	initial
		failures = 0;

	// Load runs from the cycle after load_start up to write_done
	always_ff @(posedge clock)
	begin
		if (!rst_n)
			in_load <= 1'b0;
		else if (load_start)
			in_load <= 1'b1;
		else if (write_done)
			in_load <= 1'b0;
	end

	no_plot_in_play: assert property (@(posedge clock) disable iff (!rst_n) play |-> !plot)
	else
	begin
		failures++;
		$error("plot high while in play");
	end

	stop_low_in_load: assert property (@(posedge clock) disable iff (!rst_n) in_load |-> !stop)
	else
	begin
		failures++;
		$error("stop high while a level loads");
	end

	no_restart_in_play: assert property (@(posedge clock) disable iff (!rst_n)
		play |-> !restart)
	else
	begin
		failures++;
		$error("restart high while in play");
	end

endmodule

bind maze_top maze_sva u_sva (
	.clock      (clock),
	.rst_n      (rst_n),
	.plot       (plot),
	.play       (play),
	.stop       (stop),
	.restart    (restart),
	.load_start (load_start),
	.write_done (write_done)
);

/* testbench/maze_tb.sv */
`timescale 1ns/100ps

module maze_tb import maze_pkg::*; ();

	localparam int timeout_cycles = 12000;
	localparam int tiles          = grid_w * grid_h;
	// Outcome register, then the FSM reacts
	localparam int move_latency   = 2;

	logic    clock;
	logic    rst_n;
	logic    pixel_tick;
	pix_x_t  player_x;
	pix_y_t  player_y;
	dir_t    direction;
	colour_t colour;
	pix_x_t  x_out;
	pix_y_t  y_out;
	logic    plot;
	logic    stop;
	logic    restart;

	integer  seed;
	int      cycles;
	int      errors;
	int      errors_at_start;
	int      tests_passed;
	int      tests_failed;
	int      plot_count;
	int      draws_done;
	int      col;
	int      row;
	logic    model_level;
	logic    model_key;
	logic    expect_restart;
	colour_t exp_colour;
	colour_t frame [0:tiles-1];

	maze_top dut (
		.clock      (clock),
		.rst_n      (rst_n),
		.pixel_tick (pixel_tick),
		.player_x   (player_x),
		.player_y   (player_y),
		.direction  (direction),
		.colour     (colour),
		.x_out      (x_out),
		.y_out      (y_out),
		.plot       (plot),
		.stop       (stop),
		.restart    (restart)
	);

	initial
	begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Expected tile from the level layout rules
	function automatic colour_t tile_model(input logic level, input int x, input int y,
		input logic key_taken);
		colour_t t;
		t = c_blank;
		if (x == 0 || x == 31 || y == 0 || y == 23)
			t = c_wall;
		else if (!level)
		begin
			if (x == 19)
				t = c_wall;
			else if (y == 1 && x >= 9 && x <= 11)
				t = c_trap;
			else if (x == 12 && y == 17)
				t = key_taken ? c_blank : c_key;
			else if (x == 11 && y == 2 && key_taken)
				t = c_goal;
		end
		else
		begin
			if (y == 15 && x >= 17 && x <= 23)
				t = c_trap;
			else if (x == 5 && y == 5)
				t = key_taken ? c_blank : c_key;
			else if (x == 20 && y == 10 && key_taken)
				t = c_goal;
		end
		return t;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Fail %s: expected 0x%0h, got 0x%0h at %0t", name, exp, got, $time);
		errors++;
	endtask

	task automatic drive_player(input pix_x_t px, input pix_y_t py, input dir_t dir);
		@(posedge clock);
		#1;
		player_x  = px;
		player_y  = py;
		direction = dir;
	endtask

	task automatic settle_move();
		repeat (move_latency) @(posedge clock);
		@(negedge clock);
	endtask

	// Returns one cycle after the last plot, once play has begun
	task automatic wait_draw(input int target);
		while (draws_done < target)
			@(posedge clock);
		@(negedge clock);
	endtask

	task automatic check_play_outputs();
		if (colour !== c_player)
			report_mismatch("colour", colour, c_player);
		if (x_out !== player_x)
			report_mismatch("x_out", x_out, player_x);
		if (y_out !== player_y)
			report_mismatch("y_out", y_out, player_y);
		if (plot !== 1'b0)
			report_mismatch("plot", plot, 0);
	endtask

	task automatic begin_test();
		errors_at_start = errors;
	endtask

	task automatic end_test(input string name);
		if (errors == errors_at_start)
		begin
			tests_passed++;
			$display("test %s: passed", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - errors_at_start);
		end
	endtask

	initial
	begin
		seed       = 96;
		pixel_tick = 1'b0;
		forever
		begin
			@(posedge clock);
			#1;
			pixel_tick = ($random(seed) % 2) != 0;
		end
	end

	initial
	begin
		cycles = 0;
		while (cycles < timeout_cycles)
		begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout after %0d cycles, four loads and draws should end well before",
			cycles);
		$display("SIMULATION FAILED");
		$finish;
	end

	// Compares every plotted tile against the model
	always @(negedge clock)
	begin
		if (rst_n === 1'b1 && plot === 1'b1)
		begin
			col        = plot_count % grid_w;
			row        = plot_count / grid_w;
			exp_colour = tile_model(model_level, col, row, model_key);
			if (colour !== exp_colour)
				report_mismatch("colour", colour, exp_colour);
			if (x_out !== pix_x_t'(col * tile_px))
				report_mismatch("x_out", x_out, col * tile_px);
			if (y_out !== pix_y_t'(row * tile_px))
				report_mismatch("y_out", y_out, row * tile_px);
			if (restart !== expect_restart)
				report_mismatch("restart", restart, expect_restart);
			frame[plot_count] = colour;
			plot_count++;
			if (plot_count == tiles)
			begin
				plot_count = 0;
				draws_done++;
			end
		end
	end

	initial
	begin
		errors         = 0;
		tests_passed   = 0;
		tests_failed   = 0;
		plot_count     = 0;
		draws_done     = 0;
		model_level    = 1'b0;
		model_key      = 1'b0;
		expect_restart = 1'b1;
		rst_n          = 1'b0;
		player_x       = 8'd5;
		player_y       = 7'd5;
		direction      = '0;
		repeat (10) @(posedge clock);
		#1;
		rst_n = 1'b1;

		begin_test();
		@(negedge clock);
		if (stop !== 1'b0)
			report_mismatch("stop", stop, 0);
		if (restart !== 1'b1)
			report_mismatch("restart", restart, 1);
		if (plot !== 1'b0)
			report_mismatch("plot", plot, 0);
		wait_draw(1);
		if (restart !== 1'b0)
			report_mismatch("restart", restart, 0);
		end_test("1 reset, load and first draw");

		// Tile (1,1) has the border wall on its left
		begin_test();
		check_play_outputs();
		drive_player(8'd5, 7'd5, dir_left);
		settle_move();
		if (stop !== 1'b1)
			report_mismatch("stop", stop, 1);
		if (restart !== 1'b0)
			report_mismatch("restart", restart, 0);
		drive_player(8'd5, 7'd5, '0);
		settle_move();
		if (stop !== 1'b0)
			report_mismatch("stop", stop, 0);
		drive_player(8'd5, 7'd5, dir_right);
		settle_move();
		if (stop !== 1'b0)
			report_mismatch("stop", stop, 0);
		drive_player(8'd33, 7'd47, '0);
		@(negedge clock);
		check_play_outputs();
		end_test("2 wall stop and player echo");

		begin_test();
		drive_player(8'd40, 7'd5, dir_right);
		settle_move();
		if (stop !== 1'b1)
			report_mismatch("stop", stop, 1);
		if (restart !== 1'b1)
			report_mismatch("restart", restart, 1);
		drive_player(8'd40, 7'd5, '0);
		wait_draw(2);
		if (restart !== 1'b0)
			report_mismatch("restart", restart, 0);
		check_play_outputs();
		end_test("3 trap reload");

		// Key at (12,17), approached from the left
		begin_test();
		drive_player(8'd55, 7'd85, dir_right);
		settle_move();
		if (restart !== 1'b0)
			report_mismatch("restart", restart, 0);
		model_key      = 1'b1;
		expect_restart = 1'b0;
		drive_player(8'd55, 7'd85, '0);
		wait_draw(3);
		if (frame[17 * grid_w + 12] !== c_blank)
			report_mismatch("colour at key tile", frame[17 * grid_w + 12], c_blank);
		if (frame[2 * grid_w + 11] !== c_goal)
			report_mismatch("colour at goal tile", frame[2 * grid_w + 11], c_goal);
		check_play_outputs();
		end_test("4 key pickup and goal reveal");

		begin_test();
		drive_player(8'd60, 7'd10, dir_left);
		settle_move();
		if (stop !== 1'b1)
			report_mismatch("stop", stop, 1);
		if (restart !== 1'b1)
			report_mismatch("restart", restart, 1);
		model_level    = 1'b1;
		model_key      = 1'b0;
		expect_restart = 1'b1;
		drive_player(8'd60, 7'd10, '0);
		wait_draw(4);
		if (restart !== 1'b0)
			report_mismatch("restart", restart, 0);
		check_play_outputs();
		end_test("5 goal and level 1 draw");

		if (dut.u_sva.failures != 0)
		begin
			$display("%0d assertion failures in the bound checks", dut.u_sva.failures);
			errors = errors + int'(dut.u_sva.failures);
		end
		$display("%0d tests passed, %0d failed, %0d errors", tests_passed, tests_failed,
			errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

/* all.f */
rtl/maze_pkg.sv
rtl/tile_write_if.sv
rtl/level_rom.sv
rtl/map_writer.sv
rtl/tile_map.sv
rtl/frame_drawer.sv
rtl/move_checker.sv
rtl/game_fsm.sv
rtl/maze_top.sv
testbench/maze_sva.sv
testbench/maze_tb.sv

/* Makefile */
TOP = maze_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -o sim_maze

run: build
	@out=$$(./obj_dir/sim_maze); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir
